// File: verilog.f
logic/noc_pkg.sv
logic/flit_packetizer.sv
logic/circular_buffer.sv
logic/xy_route_stage.sv
logic/noc_input_port.sv
dv/noc_input_port_tb.sv

// File: dv/noc_input_port_tb.sv
`timescale 1ns/10ps

module noc_input_port_tb;

    // router position of the DUT
    localparam noc_pkg::coord_t LOCAL_X = 2'd1;
    localparam noc_pkg::coord_t LOCAL_Y = 2'd2;
    localparam int WAIT_LIMIT = 500;

    typedef struct packed {
        noc_pkg::flit_t flit;
        noc_pkg::dir_t dir;
    } expect_t;

    logic clk;
    logic rst;
    logic pkt_start;
    logic pkt_last_only;
    noc_pkg::coord_t dest_x;
    noc_pkg::coord_t dest_y;
    logic byte_valid;
    noc_pkg::payload_t byte_data;
    logic byte_last;
    logic ready;
    logic stall;
    noc_pkg::flit_t out_flit;
    logic out_valid;
    noc_pkg::dir_t out_dir;

    expect_t exp_q[$];
    expect_t exp_now;
    string test_name;
    int error_count;
    int check_count;
    int test_count;
    int test_fail_count;
    int test_err_start;
    int hold_cycles;
    int seed_dummy;
    logic timed_out;
    logic traffic_done;
    noc_pkg::coord_t rand_x;
    noc_pkg::coord_t rand_y;

    noc_input_port #(
        .LOCAL_X (LOCAL_X),
        .LOCAL_Y (LOCAL_Y)
    ) noc_input_port_i (
        .clk             (clk),
        .rst             (rst),
        .pkt_start_i     (pkt_start),
        .pkt_last_only_i (pkt_last_only),
        .dest_x_i        (dest_x),
        .dest_y_i        (dest_y),
        .byte_valid_i    (byte_valid),
        .byte_i          (byte_data),
        .byte_last_i     (byte_last),
        .ready_o         (ready),
        .stall_i         (stall),
        .out_flit_o      (out_flit),
        .out_valid_o     (out_valid),
        .out_dir_o       (out_dir)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // XY rule, x first then y
    function automatic noc_pkg::dir_t ref_route(input noc_pkg::coord_t dx,
                                               input noc_pkg::coord_t dy);
        if (dx > LOCAL_X)
            return noc_pkg::DIR_EAST;
        if (dx < LOCAL_X)
            return noc_pkg::DIR_WEST;
        if (dy > LOCAL_Y)
            return noc_pkg::DIR_NORTH;
        if (dy < LOCAL_Y)
            return noc_pkg::DIR_SOUTH;
        return noc_pkg::DIR_LOCAL;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout in test %s: %s", test_name, what);
        timed_out = 1'b1;
        error_count++;
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!ready && !timed_out)
        begin
            next_cycle();
            waited++;
            if (waited >= WAIT_LIMIT)
                report_timeout("ready_o never came back high");
        end
    endtask

    task automatic push_expect(input noc_pkg::flit_type_t ftype, input noc_pkg::payload_t pl,
                               input noc_pkg::dir_t dir);
        expect_t e;
        e.flit.ftype = ftype;
        e.flit.payload = pl;
        e.dir = dir;
        exp_q.push_back(e);
    endtask

    // nbytes of zero makes a head_tail packet
    task automatic send_packet(input noc_pkg::coord_t dx, input noc_pkg::coord_t dy,
                               input int nbytes);
        noc_pkg::payload_t b;
        int sent;
        sent = 0;
        wait_ready();
        if (!timed_out)
        begin
            pkt_start = 1'b1;
            pkt_last_only = (nbytes == 0);
            dest_x = dx;
            dest_y = dy;
            push_expect((nbytes == 0) ? noc_pkg::FLIT_HEAD_TAIL : noc_pkg::FLIT_HEAD,
                        {dx, dy, 4'b0000}, ref_route(dx, dy));
            next_cycle();
            pkt_start = 1'b0;
            pkt_last_only = 1'b0;
        end
        while (sent < nbytes && !timed_out)
        begin
            wait_ready();
            if (!timed_out)
            begin
                b = $urandom;
                byte_valid = 1'b1;
                byte_data = b;
                byte_last = (sent == nbytes - 1);
                push_expect(byte_last ? noc_pkg::FLIT_TAIL : noc_pkg::FLIT_BODY, b,
                            ref_route(dx, dy));
                next_cycle();
                byte_valid = 1'b0;
                byte_last = 1'b0;
                sent++;
            end
        end
        // packetizer is back in idle once its last flit left the pending slot
        wait_ready();
        next_cycle();
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_err_start = error_count;
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && !timed_out)
        begin
            next_cycle();
            waited++;
            if (waited >= WAIT_LIMIT)
                report_timeout("expected flits never came out");
        end
        // a few quiet cycles to catch stray output
        repeat (4) next_cycle();
        test_count++;
        if (error_count != test_err_start)
            test_fail_count++;
        $display("test %s finished with %0d errors", test_name, error_count - test_err_start);
    endtask

    // compare on the falling edge, away from output updates
    always @(negedge clk)
    begin
        if (!rst && out_valid === 1'b1)
        begin
            check_count++;
            assert (exp_q.size() > 0)
            else
            begin
                $display("test %s: flit %h came out with nothing expected", test_name, out_flit);
                error_count++;
            end
            if (exp_q.size() > 0)
            begin
                exp_now = exp_q.pop_front();
                assert (out_flit === exp_now.flit)
                else
                begin
                    $display("ERROR %s: flit expected %h actual %h",
                             test_name, exp_now.flit, out_flit);
                    error_count++;
                end
                assert (out_dir === exp_now.dir)
                else
                begin
                    $display("ERROR %s: direction expected %0d actual %0d",
                             test_name, exp_now.dir, out_dir);
                    error_count++;
                end
            end
        end
    end

    initial
    begin
        rst = 1'b1;
        pkt_start = 1'b0;
        pkt_last_only = 1'b0;
        dest_x = '0;
        dest_y = '0;
        byte_valid = 1'b0;
        byte_data = '0;
        byte_last = 1'b0;
        stall = 1'b0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        test_fail_count = 0;
        timed_out = 1'b0;
        traffic_done = 1'b0;
        test_name = "init";
        seed_dummy = $urandom(37);
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        begin_test("reset_state");
        repeat (10)
        begin
            assert (ready === 1'b1)
            else
            begin
                $display("ERROR %s: ready_o expected 1 actual %b", test_name, ready);
                error_count++;
            end
            assert (out_valid === 1'b0)
            else
            begin
                $display("ERROR %s: out_valid_o expected 0 actual %b", test_name, out_valid);
                error_count++;
            end
            next_cycle();
        end
        end_test();

        begin_test("five_directions");
        send_packet(2'd3, 2'd1, 2);
        send_packet(2'd0, 2'd3, 2);
        send_packet(2'd1, 2'd3, 2);
        send_packet(2'd1, 2'd0, 2);
        send_packet(2'd1, 2'd2, 2);
        end_test();

        begin_test("packet_integrity");
        repeat (6)
        begin
            rand_x = $urandom;
            rand_y = $urandom;
            send_packet(rand_x, rand_y, 1 + $urandom % 12);
        end
        end_test();

        begin_test("single_flit");
        send_packet(2'd2, 2'd2, 0);
        send_packet(2'd1, 2'd2, 0);
        send_packet(2'd0, 2'd0, 0);
        send_packet(2'd1, 2'd1, 0);
        end_test();

        // more flits than the buffer plus the pending slot can hold
        begin_test("back_pressure");
        stall = 1'b1;
        fork
            send_packet(2'd3, 2'd3, noc_pkg::FIFO_DEPTH + 2);
            begin
                hold_cycles = 0;
                while (ready && !timed_out)
                begin
                    assert (out_valid === 1'b0)
                    else
                    begin
                        $display("test %s: output appeared while stalled", test_name);
                        error_count++;
                    end
                    next_cycle();
                    hold_cycles++;
                    if (hold_cycles >= WAIT_LIMIT)
                        report_timeout("ready_o never fell under stall");
                end
                repeat (20)
                begin
                    assert (ready === 1'b0 && out_valid === 1'b0)
                    else
                    begin
                        $display("test %s: ready_o rose or output appeared while stalled",
                                 test_name);
                        error_count++;
                    end
                    next_cycle();
                end
                stall = 1'b0;
            end
        join
        end_test();

        begin_test("random_traffic");
        traffic_done = 1'b0;
        fork
            begin
                repeat (40)
                begin
                    rand_x = $urandom;
                    rand_y = $urandom;
                    send_packet(rand_x, rand_y, $urandom % 13);
                end
                traffic_done = 1'b1;
            end
            while (!traffic_done)
            begin
                stall = ($urandom % 4) == 0;
                next_cycle();
            end
        join
        stall = 1'b0;
        end_test();

        $display("%0d tests run, %0d failed, %0d flits checked, %0d errors",
                 test_count, test_fail_count, check_count, error_count);
        if (error_count == 0 && !timed_out)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: logic/noc_input_port.sv
`timescale 1ns/10ps

module noc_input_port #(
    parameter noc_pkg::coord_t LOCAL_X = '0,
    parameter noc_pkg::coord_t LOCAL_Y = '0
) (
    input  logic clk,
    input  logic rst,
    input  logic pkt_start_i,
    input  logic pkt_last_only_i,
    input  noc_pkg::coord_t dest_x_i,
    input  noc_pkg::coord_t dest_y_i,
    input  logic byte_valid_i,
    input  noc_pkg::payload_t byte_i,
    input  logic byte_last_i,
    output logic ready_o,
    input  logic stall_i,
    output noc_pkg::flit_t out_flit_o,
    output logic out_valid_o,
    output noc_pkg::dir_t out_dir_o
);

    // packetizer to buffer
    noc_pkg::flit_t wr_flit;
    logic wr_en;
    logic buf_full;

    // buffer to route stage
    noc_pkg::flit_t rd_flit;
    logic rd_en;
    logic buf_empty;

    flit_packetizer flit_packetizer_i (
        .clk             (clk),
        .rst             (rst),
        .pkt_start_i     (pkt_start_i),
        .pkt_last_only_i (pkt_last_only_i),
        .dest_x_i        (dest_x_i),
        .dest_y_i        (dest_y_i),
        .byte_valid_i    (byte_valid_i),
        .byte_i          (byte_i),
        .byte_last_i     (byte_last_i),
        .buf_full_i      (buf_full),
        .ready_o         (ready_o),
        .wr_flit_o       (wr_flit),
        .wr_en_o         (wr_en)
    );

    circular_buffer #(
        .BUFFER_SIZE (noc_pkg::FIFO_DEPTH)
    ) circular_buffer_i (
        .clk        (clk),
        .rst        (rst),
        .data_i     (wr_flit),
        .write_i    (wr_en),
        .read_i     (rd_en),
        .data_o     (rd_flit),
        .is_full_o  (buf_full),
        .is_empty_o (buf_empty)
    );

    xy_route_stage #(
        .LOCAL_X (LOCAL_X),
        .LOCAL_Y (LOCAL_Y)
    ) xy_route_stage_i (
        .clk         (clk),
        .rst         (rst),
        .rd_flit_i   (rd_flit),
        .buf_empty_i (buf_empty),
        .stall_i     (stall_i),
        .rd_en_o     (rd_en),
        .out_flit_o  (out_flit_o),
        .out_valid_o (out_valid_o),
        .out_dir_o   (out_dir_o)
    );

endmodule

// File: logic/xy_route_stage.sv
`timescale 1ns/10ps

module xy_route_stage #(
    parameter noc_pkg::coord_t LOCAL_X = '0,
    parameter noc_pkg::coord_t LOCAL_Y = '0
) (
    input  logic clk,
    input  logic rst,
    input  noc_pkg::flit_t rd_flit_i,
    input  logic buf_empty_i,
    input  logic stall_i,
    output logic rd_en_o,
    output noc_pkg::flit_t out_flit_o,
    output logic out_valid_o,
    output noc_pkg::dir_t out_dir_o
);

    // coordinate fields of a head payload
    localparam int X_MSB = noc_pkg::PAYLOAD_W - 1;
    localparam int Y_MSB = noc_pkg::PAYLOAD_W - noc_pkg::COORD_W - 1;

    noc_pkg::coord_t dest_x;
    noc_pkg::coord_t dest_y;
    logic is_head;

    noc_pkg::dir_t head_dir;
    noc_pkg::dir_t route_dir;
    noc_pkg::dir_t flit_dir;

    // never read an empty buffer
    assign rd_en_o = ~buf_empty_i & ~stall_i;

    assign dest_x = rd_flit_i.payload[X_MSB -: noc_pkg::COORD_W];
    assign dest_y = rd_flit_i.payload[Y_MSB -: noc_pkg::COORD_W];

    assign is_head = (rd_flit_i.ftype == noc_pkg::FLIT_HEAD)
                  || (rd_flit_i.ftype == noc_pkg::FLIT_HEAD_TAIL);

    // dimension order, x first then y
    always_comb
    begin
        if (dest_x > LOCAL_X)
            head_dir = noc_pkg::DIR_EAST;
        else if (dest_x < LOCAL_X)
            head_dir = noc_pkg::DIR_WEST;
        else if (dest_y > LOCAL_Y)
            head_dir = noc_pkg::DIR_NORTH;
        else if (dest_y < LOCAL_Y)
            head_dir = noc_pkg::DIR_SOUTH;
        else
            head_dir = noc_pkg::DIR_LOCAL;
    end

    // body and tail follow the head's port
    assign flit_dir = is_head ? head_dir : route_dir;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_valid_o <= 1'b0;
            out_dir_o <= noc_pkg::DIR_LOCAL;
            route_dir <= noc_pkg::DIR_LOCAL;
        end
        else
        begin
            out_valid_o <= rd_en_o;
            if (rd_en_o)
            begin
                out_dir_o <= flit_dir;
                if (is_head)
                    route_dir <= head_dir;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_en_o)
            out_flit_o <= rd_flit_i;
    end

endmodule

// File: logic/circular_buffer.sv
`timescale 1ns/10ps

module circular_buffer #(
    parameter int BUFFER_SIZE = noc_pkg::FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst,
    input  noc_pkg::flit_t data_i,
    input  logic write_i,
    input  logic read_i,
    output noc_pkg::flit_t data_o,
    output logic is_full_o,
    output logic is_empty_o
);

    // enough bits to index every slot, at least one
    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    localparam ptr_t LAST_SLOT = ptr_t'(BUFFER_SIZE - 1);

    logic [noc_pkg::FLIT_W-1:0] memory [BUFFER_SIZE];

    ptr_t read_ptr;
    ptr_t write_ptr;
    ptr_t read_ptr_inc;
    ptr_t write_ptr_inc;

    ptr_t read_ptr_next;
    ptr_t write_ptr_next;
    logic is_full_next;
    logic is_empty_next;

    logic do_read;
    logic do_write;
    logic do_both;

    // wrap explicitly so odd depths work
    function automatic ptr_t ptr_inc(input ptr_t p);
        if (p == LAST_SLOT)
            return '0;
        else
            return p + 1'b1;
    endfunction

    assign read_ptr_inc = ptr_inc(read_ptr);
    assign write_ptr_inc = ptr_inc(write_ptr);

    // flit at the read pointer is always visible
    assign data_o = noc_pkg::flit_t'(memory[read_ptr]);

    assign do_read = read_i & ~write_i & ~is_empty_o;
    assign do_write = ~read_i & write_i & ~is_full_o;
    assign do_both = read_i & write_i & ~is_empty_o;

    always_comb
    begin
        unique if (do_read)
        begin
            read_ptr_next = read_ptr_inc;
            write_ptr_next = write_ptr;
            is_full_next = 1'b0;
            // last flit leaves
            is_empty_next = (read_ptr_inc == write_ptr);
        end
        else if (do_write)
        begin
            read_ptr_next = read_ptr;
            write_ptr_next = write_ptr_inc;
            // writer caught up with reader
            is_full_next = (write_ptr_inc == read_ptr);
            is_empty_next = 1'b0;
        end
        else if (do_both)
        begin
            // occupancy unchanged, flags hold
            read_ptr_next = read_ptr_inc;
            write_ptr_next = write_ptr_inc;
            is_full_next = is_full_o;
            is_empty_next = is_empty_o;
        end
        else
        begin
            read_ptr_next = read_ptr;
            write_ptr_next = write_ptr;
            is_full_next = is_full_o;
            is_empty_next = is_empty_o;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            read_ptr <= '0;
            write_ptr <= '0;
            is_full_o <= 1'b0;
            is_empty_o <= 1'b1;
        end
        else
        begin
            read_ptr <= read_ptr_next;
            write_ptr <= write_ptr_next;
            is_full_o <= is_full_next;
            is_empty_o <= is_empty_next;
        end
    end

    // a write on an empty buffer with a read also lands in memory,
    // but the write pointer stays put there
    always_ff @(posedge clk)
    begin
        if (write_i & (read_i | ~is_full_o))
            memory[write_ptr] <= data_i;
    end

endmodule

// File: logic/flit_packetizer.sv
`timescale 1ns/10ps

module flit_packetizer (
    input  logic clk,
    input  logic rst,
    input  logic pkt_start_i,
    input  logic pkt_last_only_i,
    input  noc_pkg::coord_t dest_x_i,
    input  noc_pkg::coord_t dest_y_i,
    input  logic byte_valid_i,
    input  noc_pkg::payload_t byte_i,
    input  logic byte_last_i,
    input  logic buf_full_i,
    output logic ready_o,
    output noc_pkg::flit_t wr_flit_o,
    output logic wr_en_o
);

    // zero bits below the coordinates in a head payload
    localparam int PAD_W = noc_pkg::PAYLOAD_W - 2 * noc_pkg::COORD_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SEND_HEAD,
        S_STREAM,
        S_HOLD
    } state_t;

    state_t state;
    state_t state_next;

    // one flit waiting to go into the buffer
    noc_pkg::flit_t pend_flit;
    logic pend_valid;
    logic pend_is_end;

    logic req_take;
    logic byte_take;
    noc_pkg::flit_t head_flit;
    noc_pkg::flit_t byte_flit;

    assign pend_is_end = (pend_flit.ftype == noc_pkg::FLIT_TAIL)
                      || (pend_flit.ftype == noc_pkg::FLIT_HEAD_TAIL);

    // pending slot is free unless its flit is blocked by a full buffer
    assign ready_o = ~(pend_valid & buf_full_i);
    assign wr_en_o = pend_valid & ~buf_full_i;
    assign wr_flit_o = pend_flit;

    // requests are taken in idle, or in hold once a packet's last flit can leave
    assign req_take = ((state == S_IDLE) | ((state == S_HOLD) & pend_is_end))
                    & pkt_start_i & ready_o;

    // bytes belong to an open packet, not after its tail
    assign byte_take = byte_valid_i & ready_o & (state != S_IDLE)
                     & ~(pend_valid & pend_is_end);

    always_comb
    begin
        head_flit.ftype = pkt_last_only_i ? noc_pkg::FLIT_HEAD_TAIL : noc_pkg::FLIT_HEAD;
        head_flit.payload = {dest_x_i, dest_y_i, {PAD_W{1'b0}}};
        byte_flit.ftype = byte_last_i ? noc_pkg::FLIT_TAIL : noc_pkg::FLIT_BODY;
        byte_flit.payload = byte_i;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            S_IDLE:
            begin
                // a tail may still be stuck behind a full buffer
                if (pend_valid & buf_full_i)
                    state_next = S_HOLD;
                else if (req_take)
                    state_next = S_SEND_HEAD;
            end
            S_SEND_HEAD:
            begin
                if (byte_take)
                    state_next = byte_last_i ? S_IDLE : S_STREAM;
                else if (buf_full_i)
                    state_next = S_HOLD;
                else
                    state_next = pend_is_end ? S_IDLE : S_STREAM;
            end
            S_STREAM:
            begin
                if (byte_take & byte_last_i)
                    state_next = S_IDLE;
                else if (pend_valid & buf_full_i)
                    state_next = S_HOLD;
            end
            S_HOLD:
            begin
                if (req_take)
                    state_next = S_SEND_HEAD;
                else if (byte_take)
                    state_next = byte_last_i ? S_IDLE : S_STREAM;
                else if (~buf_full_i)
                    state_next = pend_is_end ? S_IDLE : S_STREAM;
            end
            default:
                state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= S_IDLE;
            pend_valid <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (req_take | byte_take)
                pend_valid <= 1'b1;
            else if (wr_en_o)
                pend_valid <= 1'b0;
        end
    end

    // new flit replaces the one written at this edge
    always_ff @(posedge clk)
    begin
        if (req_take)
            pend_flit <= head_flit;
        else if (byte_take)
            pend_flit <= byte_flit;
    end

endmodule

// File: logic/noc_pkg.sv
package noc_pkg;

    // mesh size and derived coordinate width
    localparam int MESH_DIM = 4;
    localparam int COORD_W = $clog2(MESH_DIM);

    // payload byte carried by every flit
    localparam int PAYLOAD_W = 8;

    // default depth of the input buffer
    localparam int FIFO_DEPTH = 8;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [PAYLOAD_W-1:0] payload_t;

    // head_tail is a one-flit packet with no payload bytes
    typedef enum logic [1:0] {
        FLIT_HEAD,
        FLIT_BODY,
        FLIT_TAIL,
        FLIT_HEAD_TAIL
    } flit_type_t;

    // head payload is {dest_x, dest_y, 4'b0}
    typedef struct packed {
        flit_type_t ftype;
        payload_t payload;
    } flit_t;

    localparam int FLIT_W = $bits(flit_t);

    // output ports of a mesh router
    typedef enum logic [2:0] {
        DIR_LOCAL,
        DIR_EAST,
        DIR_WEST,
        DIR_NORTH,
        DIR_SOUTH
    } dir_t;

endpackage
